/* hdl/proc_pkg.sv */
// ##############################
// Word and field types, opcode and funct
// encodings, bubble word, halt FSM states
// ##############################
`default_nettype none

package proc_pkg;

	localparam int WORD_W    = 16;
	localparam int REG_IDX_W = 3;
	localparam int NUM_REGS  = 1 << REG_IDX_W;

	typedef logic [WORD_W-1:0]    word_t;
	typedef logic [WORD_W-1:0]    pc_t;
	typedef logic [WORD_W-1:0]    instr_t;
	typedef logic [REG_IDX_W-1:0] reg_idx_t;
	typedef logic [4:0]           opcode_t;
	typedef logic [1:0]           alu_op_t;

	// Opcode field encodings
	localparam opcode_t OP_HALT   = 5'b00000;
	localparam opcode_t OP_NOP    = 5'b00001;
	localparam opcode_t OP_J      = 5'b00100;
	localparam opcode_t OP_ADDI   = 5'b01000;
	localparam opcode_t OP_SUBI   = 5'b01001;
	localparam opcode_t OP_XORI   = 5'b01010;
	localparam opcode_t OP_ANDNI  = 5'b01011;
	localparam opcode_t OP_BEQZ   = 5'b01100;
	localparam opcode_t OP_BNEZ   = 5'b01101;
	localparam opcode_t OP_LBI    = 5'b11000;
	localparam opcode_t OP_ALU_RR = 5'b11011;

	// Register-register funct in bits 1:0
	localparam logic [1:0] FUNCT_ADD  = 2'b00;
	localparam logic [1:0] FUNCT_SUB  = 2'b01;
	localparam logic [1:0] FUNCT_XOR  = 2'b10;
	localparam logic [1:0] FUNCT_ANDN = 2'b11;

	// ALU ops reuse the funct encoding
	localparam alu_op_t ALU_ADD  = FUNCT_ADD;
	localparam alu_op_t ALU_SUB  = FUNCT_SUB;
	localparam alu_op_t ALU_XOR  = FUNCT_XOR;
	localparam alu_op_t ALU_ANDN = FUNCT_ANDN;

	// Pipeline bubble
	localparam instr_t INSTR_NOP = {OP_NOP, 11'b0};

	typedef enum logic [1:0] {
		HS_RUN    = 2'd0,
		HS_DRAIN  = 2'd1,
		HS_HALTED = 2'd2
	} halt_state_t;

endpackage

`default_nettype wire

/* hdl/pc_counter.sv */
// ##############################
// Program counter and fetch/decode
// register with squash on redirect
// ##############################
`timescale 1ns/1ps
`default_nettype none

module pc_counter import proc_pkg::*; #(
	parameter pc_t RESET_PC = '0
) (
	input  logic   clk,
	input  logic   rst_n,
	input  logic   fetch_en,
	input  logic   redirect,
	input  pc_t    redirect_pc,
	input  instr_t imem_data,
	output pc_t    imem_addr,
	output instr_t dec_instr,
	output pc_t    dec_pc_next
);

	pc_t  pc_q;
	pc_t  pc_inc;
	logic squash;

	assign pc_inc    = pc_q + 16'd2;
	assign squash    = redirect | ~fetch_en;
	assign imem_addr = pc_q;

	// Redirect takes priority over the sequential step
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc_q <= RESET_PC;
		end else if (redirect) begin
			pc_q <= redirect_pc;
		end else if (fetch_en) begin
			pc_q <= pc_inc;
		end
	end

	// Decode slot gets a bubble when the fetched word is wrong-path
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			dec_instr   <= INSTR_NOP;
			dec_pc_next <= '0;
		end else begin
			dec_instr   <= squash ? INSTR_NOP : imem_data;
			dec_pc_next <= pc_inc;
		end
	end

endmodule

`default_nettype wire

/* hdl/halt_fsm.sv */
// ##############################
// Halt FSM for fetch stop, halted and err
// ##############################
`timescale 1ns/1ps
`default_nettype none

module halt_fsm import proc_pkg::*; (
	input  logic clk,
	input  logic rst_n,
	input  logic exe_halt,
	input  logic exe_illegal,
	output logic fetch_en,
	output logic halted,
	output logic err
);

	halt_state_t state_q;
	halt_state_t state_d;
	logic        illegal_q;
	logic        stop;

	assign stop = exe_halt | exe_illegal;

	always_comb begin
		state_d = state_q;
		case (state_q)
			HS_RUN: begin
				if (stop) begin
					state_d = HS_DRAIN;
				end
			end
			HS_DRAIN:  state_d = HS_HALTED;
			HS_HALTED: state_d = HS_HALTED;
			default:   state_d = HS_RUN;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state_q   <= HS_RUN;
			illegal_q <= 1'b0;
		end else begin
			state_q <= state_d;
			// Remember why the pipeline stopped
			if (state_q == HS_RUN && stop) begin
				illegal_q <= exe_illegal;
			end
		end
	end

	// Fetch stops in the same cycle the halting instruction executes
	assign fetch_en = (state_q == HS_RUN) & ~stop;
	assign halted   = (state_q == HS_HALTED);
	assign err      = (state_q == HS_HALTED) & illegal_q;

endmodule

`default_nettype wire

/* hdl/instr_decoder.sv */
// ##############################
// Instruction decoder with control fields,
// destination select and immediate extension
// ##############################
`timescale 1ns/1ps
`default_nettype none

module instr_decoder import proc_pkg::*; (
	input  instr_t   instr,
	output reg_idx_t rs,
	output reg_idx_t rt,
	output reg_idx_t dest,
	output word_t    imm,
	output alu_op_t  alu_op,
	output logic     use_imm,
	output logic     reg_write,
	output logic     is_lbi,
	output logic     is_branch,
	output logic     branch_nez,
	output logic     is_jump,
	output logic     is_halt,
	output logic     illegal
);

	opcode_t opcode;
	word_t   imm5_sext;
	word_t   imm5_zext;
	word_t   imm8_sext;
	word_t   disp11_sext;

	assign opcode = instr[15:11];
	assign rs     = instr[10:8];
	assign rt     = instr[7:5];

	assign imm5_sext   = {{11{instr[4]}}, instr[4:0]};
	assign imm5_zext   = {11'b0, instr[4:0]};
	assign imm8_sext   = {{8{instr[7]}}, instr[7:0]};
	assign disp11_sext = {{5{instr[10]}}, instr[10:0]};

	always_comb begin
		dest       = '0;
		imm        = '0;
		alu_op     = ALU_ADD;
		use_imm    = 1'b0;
		reg_write  = 1'b0;
		is_lbi     = 1'b0;
		is_branch  = 1'b0;
		branch_nez = 1'b0;
		is_jump    = 1'b0;
		is_halt    = 1'b0;
		illegal    = 1'b0;
		case (opcode)
			OP_HALT: is_halt = 1'b1;
			OP_NOP: begin
				// No side effects
			end
			// Immediate group writes the register in bits 7:5
			OP_ADDI, OP_SUBI: begin
				dest      = instr[7:5];
				imm       = imm5_sext;
				use_imm   = 1'b1;
				reg_write = 1'b1;
				alu_op    = (opcode == OP_SUBI) ? ALU_SUB : ALU_ADD;
			end
			OP_XORI, OP_ANDNI: begin
				dest      = instr[7:5];
				imm       = imm5_zext;
				use_imm   = 1'b1;
				reg_write = 1'b1;
				alu_op    = (opcode == OP_ANDNI) ? ALU_ANDN : ALU_XOR;
			end
			OP_ALU_RR: begin
				dest      = instr[4:2];
				reg_write = 1'b1;
				alu_op    = instr[1:0];
			end
			OP_LBI: begin
				dest      = instr[10:8];
				imm       = imm8_sext;
				use_imm   = 1'b1;
				reg_write = 1'b1;
				is_lbi    = 1'b1;
			end
			OP_BEQZ, OP_BNEZ: begin
				imm        = imm8_sext;
				is_branch  = 1'b1;
				branch_nez = (opcode == OP_BNEZ);
			end
			OP_J: begin
				imm     = disp11_sext;
				is_jump = 1'b1;
			end
			default: illegal = 1'b1;
		endcase
	end

endmodule

`default_nettype wire

/* hdl/reg_file.sv */
// ##############################
// Eight-entry register file with write bypass
// ##############################
`timescale 1ns/1ps
`default_nettype none

module reg_file import proc_pkg::*; (
	input  logic     clk,
	input  logic     rst_n,
	input  reg_idx_t rd_idx_a,
	input  reg_idx_t rd_idx_b,
	input  logic     wr_en,
	input  reg_idx_t wr_idx,
	input  word_t    wr_data,
	output word_t    rd_data_a,
	output word_t    rd_data_b
);

	word_t regs_q [NUM_REGS];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs_q[i] <= '0;
			end
		end else if (wr_en) begin
			regs_q[wr_idx] <= wr_data;
		end
	end

	// Same-cycle write is visible to decode
	assign rd_data_a = (wr_en && wr_idx == rd_idx_a) ? wr_data : regs_q[rd_idx_a];
	assign rd_data_b = (wr_en && wr_idx == rd_idx_b) ? wr_data : regs_q[rd_idx_b];

endmodule

`default_nettype wire

/* hdl/execute_stage.sv */
// ##############################
// Decode/execute register, forwarding, ALU,
// branch resolution, execute/write-back register
// ##############################
`timescale 1ns/1ps
`default_nettype none

module execute_stage import proc_pkg::*; (
	input  logic     clk,
	input  logic     rst_n,
	input  reg_idx_t rs,
	input  reg_idx_t rt,
	input  reg_idx_t dest,
	input  word_t    imm,
	input  alu_op_t  alu_op,
	input  logic     use_imm,
	input  logic     reg_write,
	input  logic     is_lbi,
	input  logic     is_branch,
	input  logic     branch_nez,
	input  logic     is_jump,
	input  logic     is_halt,
	input  logic     illegal,
	input  pc_t      dec_pc_next,
	input  word_t    rd_data_a,
	input  word_t    rd_data_b,
	output logic     redirect,
	output pc_t      redirect_pc,
	output logic     exe_halt,
	output logic     exe_illegal,
	output logic     wb_valid,
	output reg_idx_t wb_idx,
	output word_t    wb_data
);

	reg_idx_t ex_rs;
	reg_idx_t ex_rt;
	reg_idx_t ex_dest;
	word_t    ex_imm;
	word_t    ex_a;
	word_t    ex_b;
	pc_t      ex_pc_next;
	alu_op_t  ex_alu_op;
	logic     ex_use_imm;
	logic     ex_branch_nez;
	logic     ex_reg_write;
	logic     ex_is_lbi;
	logic     ex_is_branch;
	logic     ex_is_jump;
	logic     ex_is_halt;
	logic     ex_illegal;

	logic  squash;
	word_t op_a;
	word_t op_b;
	word_t alu_b;
	word_t alu_out;
	word_t result;
	logic  taken;

	// Decode slot is wrong-path behind a taken branch or a stop
	assign squash = redirect | ex_is_halt | ex_illegal;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ex_reg_write <= 1'b0;
			ex_is_lbi    <= 1'b0;
			ex_is_branch <= 1'b0;
			ex_is_jump   <= 1'b0;
			ex_is_halt   <= 1'b0;
			ex_illegal   <= 1'b0;
		end else begin
			ex_reg_write <= reg_write & ~squash;
			ex_is_lbi    <= is_lbi & ~squash;
			ex_is_branch <= is_branch & ~squash;
			ex_is_jump   <= is_jump & ~squash;
			ex_is_halt   <= is_halt & ~squash;
			ex_illegal   <= illegal & ~squash;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ex_rs         <= '0;
			ex_rt         <= '0;
			ex_dest       <= '0;
			ex_imm        <= '0;
			ex_a          <= '0;
			ex_b          <= '0;
			ex_pc_next    <= '0;
			ex_alu_op     <= ALU_ADD;
			ex_use_imm    <= 1'b0;
			ex_branch_nez <= 1'b0;
		end else begin
			ex_rs         <= rs;
			ex_rt         <= rt;
			ex_dest       <= dest;
			ex_imm        <= imm;
			ex_a          <= rd_data_a;
			ex_b          <= rd_data_b;
			ex_pc_next    <= dec_pc_next;
			ex_alu_op     <= alu_op;
			ex_use_imm    <= use_imm;
			ex_branch_nez <= branch_nez;
		end
	end

	// Forward from the write-back register
	assign op_a  = (wb_valid && wb_idx == ex_rs) ? wb_data : ex_a;
	assign op_b  = (wb_valid && wb_idx == ex_rt) ? wb_data : ex_b;
	assign alu_b = ex_use_imm ? ex_imm : op_b;

	// Subtract is B minus A
	always_comb begin
		case (ex_alu_op)
			ALU_ADD:  alu_out = op_a + alu_b;
			ALU_SUB:  alu_out = alu_b - op_a;
			ALU_XOR:  alu_out = op_a ^ alu_b;
			ALU_ANDN: alu_out = op_a & ~alu_b;
			default:  alu_out = '0;
		endcase
	end

	assign result = ex_is_lbi ? ex_imm : alu_out;

	// BEQZ and BNEZ test Rs
	assign taken       = ex_is_branch & (ex_branch_nez ? (op_a != '0) : (op_a == '0));
	assign redirect    = taken | ex_is_jump;
	assign redirect_pc = ex_pc_next + ex_imm;
	assign exe_halt    = ex_is_halt;
	assign exe_illegal = ex_illegal;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wb_valid <= 1'b0;
			wb_idx   <= '0;
			wb_data  <= '0;
		end else begin
			wb_valid <= ex_reg_write;
			wb_idx   <= ex_dest;
			wb_data  <= result;
		end
	end

endmodule

`default_nettype wire

/* hdl/proc_top.sv */
// ##############################
// Four-stage 16-bit processor top level
// ##############################
`timescale 1ns/1ps
`default_nettype none

module proc_top import proc_pkg::*; #(
	parameter pc_t RESET_PC = '0
) (
	input  logic     clk,
	input  logic     rst_n,
	input  instr_t   imem_data,
	output pc_t      imem_addr,
	output logic     retire_valid,
	output reg_idx_t retire_reg,
	output word_t    retire_data,
	output logic     halted,
	output logic     err
);

	logic     fetch_en;
	logic     redirect;
	pc_t      redirect_pc;
	instr_t   dec_instr;
	pc_t      dec_pc_next;
	reg_idx_t rs;
	reg_idx_t rt;
	reg_idx_t dest;
	word_t    imm;
	alu_op_t  alu_op;
	logic     use_imm;
	logic     reg_write;
	logic     is_lbi;
	logic     is_branch;
	logic     branch_nez;
	logic     is_jump;
	logic     is_halt;
	logic     illegal;
	word_t    rd_data_a;
	word_t    rd_data_b;
	logic     exe_halt;
	logic     exe_illegal;
	logic     wb_valid;
	reg_idx_t wb_idx;
	word_t    wb_data;

	pc_counter #(
		.RESET_PC(RESET_PC)
	) pc_counter_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.fetch_en   (fetch_en),
		.redirect   (redirect),
		.redirect_pc(redirect_pc),
		.imem_data  (imem_data),
		.imem_addr  (imem_addr),
		.dec_instr  (dec_instr),
		.dec_pc_next(dec_pc_next)
	);

	halt_fsm halt_fsm_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.exe_halt   (exe_halt),
		.exe_illegal(exe_illegal),
		.fetch_en   (fetch_en),
		.halted     (halted),
		.err        (err)
	);

	instr_decoder instr_decoder_i (
		.instr     (dec_instr),
		.rs        (rs),
		.rt        (rt),
		.dest      (dest),
		.imm       (imm),
		.alu_op    (alu_op),
		.use_imm   (use_imm),
		.reg_write (reg_write),
		.is_lbi    (is_lbi),
		.is_branch (is_branch),
		.branch_nez(branch_nez),
		.is_jump   (is_jump),
		.is_halt   (is_halt),
		.illegal   (illegal)
	);

	// Written from the write-back register
	reg_file reg_file_i (
		.clk      (clk),
		.rst_n    (rst_n),
		.rd_idx_a (rs),
		.rd_idx_b (rt),
		.wr_en    (wb_valid),
		.wr_idx   (wb_idx),
		.wr_data  (wb_data),
		.rd_data_a(rd_data_a),
		.rd_data_b(rd_data_b)
	);

	execute_stage execute_stage_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.rs         (rs),
		.rt         (rt),
		.dest       (dest),
		.imm        (imm),
		.alu_op     (alu_op),
		.use_imm    (use_imm),
		.reg_write  (reg_write),
		.is_lbi     (is_lbi),
		.is_branch  (is_branch),
		.branch_nez (branch_nez),
		.is_jump    (is_jump),
		.is_halt    (is_halt),
		.illegal    (illegal),
		.dec_pc_next(dec_pc_next),
		.rd_data_a  (rd_data_a),
		.rd_data_b  (rd_data_b),
		.redirect   (redirect),
		.redirect_pc(redirect_pc),
		.exe_halt   (exe_halt),
		.exe_illegal(exe_illegal),
		.wb_valid   (wb_valid),
		.wb_idx     (wb_idx),
		.wb_data    (wb_data)
	);

	// Retirement is the write-back bus
	assign retire_valid = wb_valid;
	assign retire_reg   = wb_idx;
	assign retire_data  = wb_data;

endmodule

`default_nettype wire

/* sim/proc_properties.sv */
// ##############################
// Assertions on halted, fetch
// alignment and retirement
// ##############################
`timescale 1ns/1ps
`default_nettype none

module proc_properties import proc_pkg::*; (
	input logic clk,
	input logic rst_n,
	input pc_t  imem_addr,
	input logic retire_valid,
	input logic halted
);

	// Only reset clears halted
	halted_sticky: assert property (
		@(posedge clk) disable iff (!rst_n) halted |=> halted
	) else $error("halted fell without a reset");

	// Instructions are two bytes
	pc_even: assert property (
		@(posedge clk) disable iff (!rst_n) imem_addr[0] == 1'b0
	) else $error("imem_addr is odd");

	no_retire_when_halted: assert property (
		@(posedge clk) disable iff (!rst_n) halted |-> !retire_valid
	) else $error("retire_valid high while halted");

endmodule

bind proc_top proc_properties proc_properties_i (
	.clk         (clk),
	.rst_n       (rst_n),
	.imem_addr   (imem_addr),
	.retire_valid(retire_valid),
	.halted      (halted)
);

`default_nettype wire

/* sim/proc_tb.sv */
// ##############################
// Processor testbench with clock, reset,
// instruction memory model, ISA model,
// directed and random program tests
// ##############################
`timescale 1ns/1ps
`default_nettype none

module proc_tb import proc_pkg::*;;

	localparam pc_t RESET_PC       = 16'h0000;
	localparam int  IMEM_WORDS     = 256;
	localparam int  TIMEOUT_CYCLES = 500;
	localparam int  MODEL_STEPS    = 200;

	logic     clk;
	logic     rst_n;
	instr_t   imem_data;
	pc_t      imem_addr;
	logic     retire_valid;
	reg_idx_t retire_reg;
	word_t    retire_data;
	logic     halted;
	logic     err;

	instr_t   imem [IMEM_WORDS];
	int       prog_len;
	integer   seed;

	// Expected retirements from the ISA model
	word_t    model_regs [NUM_REGS];
	reg_idx_t exp_reg [$];
	word_t    exp_data [$];
	logic     exp_err;

	proc_top #(
		.RESET_PC(RESET_PC)
	) proc_top_i (
		.clk         (clk),
		.rst_n       (rst_n),
		.imem_data   (imem_data),
		.imem_addr   (imem_addr),
		.retire_valid(retire_valid),
		.retire_reg  (retire_reg),
		.retire_data (retire_data),
		.halted      (halted),
		.err         (err)
	);

	// Combinational instruction memory, word addressed
	assign imem_data = imem[imem_addr[8:1]];

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("TESTS FAILED");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_word(input string test, input word_t exp, input word_t act);
		if (exp !== act) begin
			fail_run($sformatf("MISMATCH %s: expected %h, actual %h", test, exp, act));
		end
	endtask

	task automatic check_reg(input string test, input reg_idx_t exp, input reg_idx_t act);
		if (exp !== act) begin
			fail_run($sformatf("MISMATCH %s: expected r%0d, actual r%0d", test, exp, act));
		end
	endtask

	task automatic check_flag(input string test, input logic exp, input logic act);
		if (exp !== act) begin
			fail_run($sformatf("MISMATCH %s: expected %b, actual %b", test, exp, act));
		end
	endtask

	// Instruction encoders
	function automatic instr_t rr_word(input logic [1:0] funct, input reg_idx_t rd,
			input reg_idx_t rs, input reg_idx_t rt);
		return {OP_ALU_RR, rs, rt, rd, funct};
	endfunction

	function automatic instr_t imm_word(input opcode_t op, input reg_idx_t rd,
			input reg_idx_t rs, input logic [4:0] imm5);
		return {op, rs, rd, imm5};
	endfunction

	function automatic instr_t lbi_word(input reg_idx_t rs, input logic [7:0] imm8);
		return {OP_LBI, rs, imm8};
	endfunction

	function automatic instr_t branch_word(input opcode_t op, input reg_idx_t rs,
			input logic [7:0] off);
		return {op, rs, off};
	endfunction

	function automatic instr_t jump_word(input logic [10:0] disp);
		return {OP_J, disp};
	endfunction

	// Unused words hold HALT so a runaway fetch stops
	task automatic clear_imem();
		for (int i = 0; i < IMEM_WORDS; i++) begin
			imem[i] = {OP_HALT, 11'b0};
		end
		prog_len = 0;
	endtask

	task automatic emit(input instr_t w);
		imem[(RESET_PC >> 1) + prog_len] = w;
		prog_len++;
	endtask

	task automatic record_write(input reg_idx_t rd, input word_t val);
		model_regs[rd] = val;
		exp_reg.push_back(rd);
		exp_data.push_back(val);
	endtask

	// Architectural model of the program in imem
	task automatic model_program();
		pc_t     pc;
		instr_t  ins;
		opcode_t op;
		word_t   a;
		word_t   b;
		word_t   s5;
		word_t   z5;
		word_t   s8;
		logic    done;
		int      steps;
		exp_reg.delete();
		exp_data.delete();
		exp_err = 1'b0;
		for (int i = 0; i < NUM_REGS; i++) begin
			model_regs[i] = '0;
		end
		pc = RESET_PC;
		done = 1'b0;
		steps = 0;
		while (!done) begin
			ins = imem[pc[8:1]];
			op  = ins[15:11];
			a   = model_regs[ins[10:8]];
			b   = model_regs[ins[7:5]];
			s5  = {{11{ins[4]}}, ins[4:0]};
			z5  = {11'b0, ins[4:0]};
			s8  = {{8{ins[7]}}, ins[7:0]};
			pc  = pc + 16'd2;
			case (op)
				OP_HALT:  done = 1'b1;
				OP_NOP:   done = 1'b0;
				OP_ADDI:  record_write(ins[7:5], a + s5);
				OP_SUBI:  record_write(ins[7:5], s5 - a);
				OP_XORI:  record_write(ins[7:5], a ^ z5);
				OP_ANDNI: record_write(ins[7:5], a & ~z5);
				OP_LBI:   record_write(ins[10:8], s8);
				OP_BEQZ:  pc = (a == '0) ? pc + s8 : pc;
				OP_BNEZ:  pc = (a != '0) ? pc + s8 : pc;
				OP_J:     pc = pc + {{5{ins[10]}}, ins[10:0]};
				OP_ALU_RR: begin
					case (ins[1:0])
						FUNCT_ADD: record_write(ins[4:2], a + b);
						FUNCT_SUB: record_write(ins[4:2], b - a);
						FUNCT_XOR: record_write(ins[4:2], a ^ b);
						default:   record_write(ins[4:2], a & ~b);
					endcase
				end
				default: begin
					exp_err = 1'b1;
					done = 1'b1;
				end
			endcase
			steps++;
			if (steps > MODEL_STEPS) begin
				fail_run("The reference model did not reach a halt within its step limit");
			end
		end
	endtask

	// Reset the DUT, run the loaded program and match every retirement
	task automatic run_program(input string name);
		int idx;
		int cycles;
		model_program();
		@(posedge clk);
		rst_n <= 1'b0;
		repeat (9) @(posedge clk);
		@(negedge clk);
		check_word({name, " reset pc"}, RESET_PC, imem_addr);
		check_flag({name, " reset retire_valid"}, 1'b0, retire_valid);
		check_flag({name, " reset halted"}, 1'b0, halted);
		check_flag({name, " reset err"}, 1'b0, err);
		@(posedge clk);
		rst_n <= 1'b1;
		idx = 0;
		cycles = 0;
		while (!halted) begin
			@(negedge clk);
			if (retire_valid) begin
				if (idx >= exp_reg.size()) begin
					fail_run($sformatf("%s: unexpected retirement to r%0d", name, retire_reg));
				end
				check_reg(name, exp_reg[idx], retire_reg);
				check_word(name, exp_data[idx], retire_data);
				idx++;
			end
			// err only rises together with halted
			if (!halted) begin
				check_flag({name, " err before halted"}, 1'b0, err);
			end
			cycles++;
			if (cycles > TIMEOUT_CYCLES) begin
				fail_run($sformatf("%s: timed out waiting for halted", name));
			end
		end
		if (idx != exp_reg.size()) begin
			fail_run($sformatf("MISMATCH %s: expected %0d retirements, actual %0d",
				name, exp_reg.size(), idx));
		end
		check_flag({name, " err"}, exp_err, err);
		// Nothing retires while halted
		repeat (4) begin
			@(negedge clk);
			check_flag({name, " retire after halt"}, 1'b0, retire_valid);
			check_flag({name, " halted held"}, 1'b1, halted);
		end
	endtask

	task automatic imm_group_test();
		clear_imem();
		emit(lbi_word(3'd1, 8'h35));
		emit(lbi_word(3'd2, 8'hFD));
		emit(imm_word(OP_ADDI, 3'd3, 3'd1, 5'h1C));
		emit(imm_word(OP_SUBI, 3'd4, 3'd2, 5'h07));
		emit(imm_word(OP_XORI, 3'd5, 3'd3, 5'h1F));
		emit(imm_word(OP_ANDNI, 3'd6, 3'd2, 5'h15));
		emit(imm_word(OP_ADDI, 3'd7, 3'd6, 5'h10));
		emit({OP_HALT, 11'b0});
		run_program("imm_group");
	endtask

	// Each op reads the result just before it
	task automatic rr_forwarding_test();
		clear_imem();
		emit(lbi_word(3'd1, 8'h07));
		emit(lbi_word(3'd2, 8'hFE));
		emit(rr_word(FUNCT_ADD, 3'd3, 3'd1, 3'd2));
		emit(rr_word(FUNCT_SUB, 3'd4, 3'd1, 3'd3));
		emit(rr_word(FUNCT_XOR, 3'd5, 3'd4, 3'd3));
		emit(rr_word(FUNCT_ANDN, 3'd6, 3'd5, 3'd4));
		emit(rr_word(FUNCT_ADD, 3'd7, 3'd6, 3'd6));
		emit(rr_word(FUNCT_SUB, 3'd1, 3'd7, 3'd7));
		emit({OP_HALT, 11'b0});
		run_program("rr_forwarding");
	endtask

	task automatic branch_test();
		clear_imem();
		emit(lbi_word(3'd1, 8'h00));
		emit(lbi_word(3'd2, 8'h05));
		emit(branch_word(OP_BEQZ, 3'd1, 8'd4));
		emit(lbi_word(3'd3, 8'h01));
		emit(lbi_word(3'd3, 8'h02));
		emit(branch_word(OP_BNEZ, 3'd1, 8'd4));
		emit(lbi_word(3'd4, 8'h03));
		emit(branch_word(OP_BEQZ, 3'd2, 8'd2));
		emit(lbi_word(3'd5, 8'h04));
		emit(branch_word(OP_BNEZ, 3'd2, 8'd4));
		emit(lbi_word(3'd6, 8'h05));
		emit(lbi_word(3'd6, 8'h06));
		emit(jump_word(11'd4));
		emit(lbi_word(3'd7, 8'h07));
		emit(lbi_word(3'd7, 8'h08));
		emit(imm_word(OP_ADDI, 3'd3, 3'd2, 5'h01));
		emit({OP_HALT, 11'b0});
		run_program("branches");
	endtask

	task automatic random_program_test();
		opcode_t     imm_ops [4];
		logic [31:0] r;
		imm_ops = '{OP_ADDI, OP_SUBI, OP_XORI, OP_ANDNI};
		for (int p = 0; p < 10; p++) begin
			clear_imem();
			for (int i = 0; i < 12; i++) begin
				r = $random(seed);
				case (r[31:30])
					2'd0:    emit({OP_ALU_RR, r[10:0]});
					2'd1:    emit({OP_LBI, r[10:0]});
					default: emit({imm_ops[r[29:28]], r[10:0]});
				endcase
			end
			emit({OP_HALT, 11'b0});
			run_program($sformatf("random_program_%0d", p));
		end
	endtask

	task automatic halt_test();
		clear_imem();
		emit(lbi_word(3'd1, 8'h09));
		emit({OP_HALT, 11'b0});
		emit(lbi_word(3'd2, 8'h01));
		emit(lbi_word(3'd3, 8'h02));
		run_program("halt");
		// 11111 is not a listed opcode
		clear_imem();
		emit(lbi_word(3'd1, 8'h09));
		emit(16'hF800);
		emit(lbi_word(3'd2, 8'h01));
		emit(lbi_word(3'd3, 8'h02));
		run_program("illegal_opcode");
	endtask

	initial begin
		rst_n = 1'b0;
		seed = 53;
		clear_imem();
		imm_group_test();
		rr_forwarding_test();
		branch_test();
		random_program_test();
		halt_test();
		$display("TESTS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

/* tb.f */
hdl/proc_pkg.sv
hdl/pc_counter.sv
hdl/halt_fsm.sv
hdl/instr_decoder.sv
hdl/reg_file.sv
hdl/execute_stage.sv
hdl/proc_top.sv
sim/proc_properties.sv
sim/proc_tb.sv

/* Bender.yml */
package:
  name: proc

sources:
  - files:
      - hdl/proc_pkg.sv
      - hdl/pc_counter.sv
      - hdl/halt_fsm.sv
      - hdl/instr_decoder.sv
      - hdl/reg_file.sv
      - hdl/execute_stage.sv
      - hdl/proc_top.sv
  - target: simulation
    files:
      - sim/proc_properties.sv
      - sim/proc_tb.sv
